//--- Makefile
TOOL       = verilator
TOP        = tb_rv_core
FILELIST   = src.f
OBJ_DIR    = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only --timing -Wall -Wno-fatal
SIM_FLAGS  = --binary --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/rv_alu.sv
module rv_alu
  import rv_pkg::*;
(
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] y_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD:  y_o = a_i + b_i;
      ALU_SUB:  y_o = a_i - b_i;
      ALU_SLL:  y_o = a_i << shamt;
      ALU_SLT:  y_o = XLEN'($signed(a_i) < $signed(b_i));
      ALU_SLTU: y_o = XLEN'(a_i < b_i);
      ALU_XOR:  y_o = a_i ^ b_i;
      ALU_SRL:  y_o = a_i >> shamt;
      // arithmetic shift keeps the sign
      ALU_SRA:  y_o = $unsigned($signed(a_i) >>> shamt);
      ALU_OR:   y_o = a_i | b_i;
      ALU_AND:  y_o = a_i & b_i;
      default:  y_o = '0;
    endcase
  end

endmodule

//--- rtl/rv_core.sv
module rv_core
  import rv_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  output logic [XLEN-1:0] pc_o,
  input  logic [XLEN-1:0] inst_i,
  output retire_t         retire_o
);

  if_id_t                if_id;
  id_ex_t                id_ex;
  logic                  redirect;
  logic [XLEN-1:0]       redirect_pc;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [XLEN-1:0]       rdata1;
  logic [XLEN-1:0]       rdata2;

  rv_fetch fetch_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .inst_i        (inst_i),
    .pc_o          (pc_o),
    .if_id_o       (if_id)
  );

  // a redirect squashes both younger stages
  rv_decode decode_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .flush_i  (redirect),
    .if_id_i  (if_id),
    .rs1_o    (rs1),
    .rs2_o    (rs2),
    .rdata1_i (rdata1),
    .rdata2_i (rdata2),
    .id_ex_o  (id_ex)
  );

  // write port is the retire stream itself
  rv_regfile regfile_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .wr_i     (retire_o)
  );

  rv_execute execute_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .id_ex_i       (id_ex),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .retire_o      (retire_o)
  );

endmodule

//--- rtl/rv_decode.sv
module rv_decode
  import rv_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  input  if_id_t                if_id_i,
  output logic [REG_ADDR_W-1:0] rs1_o,
  output logic [REG_ADDR_W-1:0] rs2_o,
  input  logic [XLEN-1:0]       rdata1_i,
  input  logic [XLEN-1:0]       rdata2_i,
  output id_ex_t                id_ex_o
);

  logic [XLEN-1:0] inst;
  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_b;
  logic            if_id_valid_q;
  id_ex_t          id_ex_d;
  id_ex_t          id_ex_q;

  // funct3 plus funct7 bit 5 to alu op; sub only exists for register ops
  function automatic alu_op_e alu_op_decode(input logic [2:0] f3,
                                            input logic       f7_b5,
                                            input logic       reg_op);
    alu_op_e op;
    case (f3)
      3'b000:  op = (reg_op && f7_b5) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = f7_b5 ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // ====================
  // fields and immediates
  // ====================

  assign inst   = if_id_i.inst;
  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rs1_o  = inst[19:15];
  assign rs2_o  = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

  // ====================
  // control decode
  // ====================

  always_comb begin
    id_ex_d          = '0;
    id_ex_d.valid    = if_id_valid_q;
    id_ex_d.pc       = if_id_i.pc;
    id_ex_d.rs1      = rs1_o;
    id_ex_d.rs2      = rs2_o;
    id_ex_d.rs1_data = rdata1_i;
    id_ex_d.rs2_data = rdata2_i;
    id_ex_d.rd       = inst[11:7];
    id_ex_d.funct3   = funct3;
    case (opcode)
      OPC_OP: begin
        id_ex_d.alu_op    = alu_op_decode(funct3, funct7[5], 1'b1);
        id_ex_d.reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        id_ex_d.alu_op      = alu_op_decode(funct3, funct7[5], 1'b0);
        id_ex_d.imm         = imm_i;
        id_ex_d.alu_src_imm = 1'b1;
        id_ex_d.reg_write   = 1'b1;
      end
      OPC_LUI: begin
        id_ex_d.imm       = imm_u;
        id_ex_d.is_lui    = 1'b1;
        id_ex_d.reg_write = 1'b1;
      end
      OPC_AUIPC: begin
        id_ex_d.imm         = imm_u;
        id_ex_d.op1_pc      = 1'b1;
        id_ex_d.alu_src_imm = 1'b1;
        id_ex_d.reg_write   = 1'b1;
      end
      OPC_JAL: begin
        id_ex_d.imm       = imm_j;
        id_ex_d.is_jal    = 1'b1;
        id_ex_d.reg_write = 1'b1;
      end
      OPC_JALR: begin
        id_ex_d.imm       = imm_i;
        id_ex_d.is_jalr   = 1'b1;
        id_ex_d.reg_write = 1'b1;
      end
      OPC_BRANCH: begin
        id_ex_d.imm       = imm_b;
        id_ex_d.is_branch = 1'b1;
      end
      default: begin
        // unsupported, behaves as nop
        id_ex_d.rd = '0;
      end
    endcase
  end

  // IF/ID holds a nop after reset or a flush, so track whether it is real
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      if_id_valid_q <= 1'b0;
    end else begin
      if_id_valid_q <= 1'b1;
    end
  end

  // ID/EX register, all zero is a bubble
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      id_ex_q <= '0;
    end else begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

//--- rtl/rv_execute.sv
module rv_execute
  import rv_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  id_ex_t          id_ex_i,
  output logic            redirect_o,
  output logic [XLEN-1:0] redirect_pc_o,
  output retire_t         retire_o
);

  retire_t         retire_q;
  logic            wb_hit;
  logic            fwd1;
  logic            fwd2;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_y;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] result;
  logic            taken;

  // ====================
  // forwarding
  // ====================

  // previous instruction's result sits in EX/WB
  assign wb_hit  = retire_q.valid && retire_q.reg_write && (retire_q.rd != '0);
  assign fwd1    = wb_hit && (retire_q.rd == id_ex_i.rs1);
  assign fwd2    = wb_hit && (retire_q.rd == id_ex_i.rs2);
  assign rs1_val = fwd1 ? retire_q.wdata : id_ex_i.rs1_data;
  assign rs2_val = fwd2 ? retire_q.wdata : id_ex_i.rs2_data;

  assign alu_a = id_ex_i.op1_pc ? id_ex_i.pc : rs1_val;
  assign alu_b = id_ex_i.alu_src_imm ? id_ex_i.imm : rs2_val;

  rv_alu alu_inst (
    .op_i (id_ex_i.alu_op),
    .a_i  (alu_a),
    .b_i  (alu_b),
    .y_o  (alu_y)
  );

  // ====================
  // branch and jump
  // ====================

  always_comb begin
    case (id_ex_i.funct3)
      BR_BEQ:  taken = (rs1_val == rs2_val);
      BR_BNE:  taken = (rs1_val != rs2_val);
      BR_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
      BR_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
      BR_BLTU: taken = (rs1_val < rs2_val);
      BR_BGEU: taken = (rs1_val >= rs2_val);
      default: taken = 1'b0;
    endcase
  end

  assign jalr_sum = rs1_val + id_ex_i.imm;

  // jalr target has bit 0 cleared
  assign redirect_pc_o = id_ex_i.is_jalr ? {jalr_sum[XLEN-1:1], 1'b0}
                                         : id_ex_i.pc + id_ex_i.imm;
  assign redirect_o    = id_ex_i.valid &&
                         (id_ex_i.is_jal || id_ex_i.is_jalr || (id_ex_i.is_branch && taken));

  // ====================
  // result and EX/WB
  // ====================

  assign pc_plus4 = id_ex_i.pc + XLEN'(4);
  assign result   = id_ex_i.is_lui                      ? id_ex_i.imm :
                    (id_ex_i.is_jal || id_ex_i.is_jalr) ? pc_plus4    :
                                                          alu_y;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      retire_q <= '0;
    end else begin
      retire_q.valid     <= id_ex_i.valid;
      retire_q.pc        <= id_ex_i.pc;
      retire_q.rd        <= id_ex_i.rd;
      retire_q.reg_write <= id_ex_i.valid && id_ex_i.reg_write;
      retire_q.wdata     <= result;
    end
  end

  assign retire_o = retire_q;

endmodule

//--- rtl/rv_fetch.sv
module rv_fetch
  import rv_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            redirect_i,
  input  logic [XLEN-1:0] redirect_pc_i,
  input  logic [XLEN-1:0] inst_i,
  output logic [XLEN-1:0] pc_o,
  output if_id_t          if_id_o
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_next;
  if_id_t          if_id_q;

  // resolved branch or jump wins over sequential fetch
  assign pc_next = redirect_i ? redirect_pc_i : pc_q + XLEN'(4);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  // ====================
  // IF/ID register
  // ====================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      if_id_q.pc   <= RESET_PC;
      if_id_q.inst <= NOP_INST;
    end else if (redirect_i) begin
      // wrong-path fetch, squash to nop
      if_id_q.pc   <= pc_q;
      if_id_q.inst <= NOP_INST;
    end else begin
      if_id_q.pc   <= pc_q;
      if_id_q.inst <= inst_i;
    end
  end

  assign pc_o    = pc_q;
  assign if_id_o = if_id_q;

endmodule

//--- rtl/rv_pkg.sv
package rv_pkg;

  // ====================
  // widths and constants
  // ====================

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [XLEN-1:0] RESET_PC = '0;

  // addi x0,x0,0
  localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

  // branch conditions by funct3
  localparam logic [2:0] BR_BEQ  = 3'b000;
  localparam logic [2:0] BR_BNE  = 3'b001;
  localparam logic [2:0] BR_BLT  = 3'b100;
  localparam logic [2:0] BR_BGE  = 3'b101;
  localparam logic [2:0] BR_BLTU = 3'b110;
  localparam logic [2:0] BR_BGEU = 3'b111;

  // ====================
  // opcodes
  // ====================

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // ALU_ADD must stay zero, a cleared stage register then decodes as a plain add
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // ====================
  // pipeline registers
  // ====================

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } if_id_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    logic [2:0]            funct3;
    alu_op_e               alu_op;
    logic                  alu_src_imm;
    logic                  op1_pc;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_lui;
    logic                  reg_write;
  } id_ex_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write;
    logic [XLEN-1:0]       wdata;
  } retire_t;

endpackage

//--- rtl/rv_regfile.sv
module rv_regfile
  import rv_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [REG_ADDR_W-1:0] raddr1_i,
  input  logic [REG_ADDR_W-1:0] raddr2_i,
  output logic [XLEN-1:0]       rdata1_o,
  output logic [XLEN-1:0]       rdata2_o,
  input  retire_t               wr_i
);

  // x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];
  logic            wr_en;

  assign wr_en = wr_i.valid && wr_i.reg_write && (wr_i.rd != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wr_i.rd] <= wr_i.wdata;
    end
  end

  // write-through so decode sees this cycle's write-back
  assign rdata1_o = (raddr1_i == '0)                   ? '0         :
                    (wr_en && (wr_i.rd == raddr1_i))   ? wr_i.wdata :
                                                         regs_q[raddr1_i];
  assign rdata2_o = (raddr2_i == '0)                   ? '0         :
                    (wr_en && (wr_i.rd == raddr2_i))   ? wr_i.wdata :
                                                         regs_q[raddr2_i];

endmodule

//--- src.f
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_fetch.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_core.sv
tb/rv_model_pkg.sv
tb/tb_rv_core.sv

//--- tb/rv_model_pkg.sv
package rv_model_pkg;
  import rv_pkg::*;

  localparam int PROG_LEN = 32;

  // instruction kinds, also the column order of the mix table
  localparam logic [2:0] K_REG    = 3'd0;
  localparam logic [2:0] K_IMM    = 3'd1;
  localparam logic [2:0] K_UPPER  = 3'd2;
  localparam logic [2:0] K_BRANCH = 3'd3;
  localparam logic [2:0] K_JAL    = 3'd4;
  localparam logic [2:0] K_JALR   = 3'd5;

  // weights per test: reg, imm, upper, branch, jal, jalr
  localparam int MIX [1:6][6] = '{
    '{0, 4, 1, 0, 0, 0},
    '{6, 2, 0, 0, 0, 0},
    '{0, 5, 3, 0, 0, 0},
    '{4, 3, 1, 0, 0, 0},
    '{2, 2, 0, 4, 0, 0},
    '{2, 2, 0, 0, 2, 2}
  };
  // highest register per test, a small set forces dependencies
  localparam int REG_MAX [1:6] = '{7, 7, 7, 3, 3, 7};

  // what the generator chose for one program slot
  typedef struct packed {
    logic [2:0]      kind;
    logic [2:0]      f3;
    logic            alt;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm;
  } slot_t;

  slot_t           slots [PROG_LEN];
  logic [XLEN-1:0] prog  [PROG_LEN];
  retire_t         exp_q [$];

  function automatic logic [2:0] pick_kind(input int test_id);
    int total;
    int r;
    total = 0;
    for (int k = 0; k < 6; k++) begin
      total += MIX[test_id][k];
    end
    r = int'($urandom_range(total - 1, 0));
    for (int k = 0; k < 6; k++) begin
      if (r < MIX[test_id][k]) begin
        return 3'(k);
      end
      r -= MIX[test_id][k];
    end
    return K_REG;
  endfunction

  // ====================
  // program generator
  // ====================

  function automatic void gen_program(input int test_id);
    slot_t           s;
    logic [XLEN-1:0] r;
    int              tgt;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      r      = $urandom;
      tgt    = int'($urandom_range(PROG_LEN - 1, i + 1));
      s.kind = pick_kind(test_id);
      s.f3   = r[14:12];
      s.alt  = r[30];
      s.rd   = 5'($urandom_range(REG_MAX[test_id], 0));
      s.rs1  = 5'($urandom_range(REG_MAX[test_id], 0));
      s.rs2  = 5'($urandom_range(REG_MAX[test_id], 0));
      s.imm  = {{20{r[11]}}, r[11:0]};
      case (s.kind)
        K_REG: begin
          s.alt   = s.alt && (s.f3 == 3'd0 || s.f3 == 3'd5);
          prog[i] = {1'b0, s.alt, 5'b0, s.rs2, s.rs1, s.f3, s.rd, OPC_OP};
        end
        K_IMM: begin
          s.alt = s.alt && (s.f3 == 3'd5);
          if (s.f3 == 3'd1 || s.f3 == 3'd5) begin
            s.imm = {27'b0, r[4:0]};
          end
          prog[i] = {s.imm[11:0] | {1'b0, s.alt, 10'b0}, s.rs1, s.f3, s.rd, OPC_OP_IMM};
        end
        K_UPPER: begin
          s.imm   = {r[31:12], 12'b0};
          prog[i] = {s.imm[31:12], s.rd, s.alt ? OPC_AUIPC : OPC_LUI};
        end
        K_BRANCH: begin
          // funct3 2 and 3 are not branches, fold onto ltu and geu
          if (s.f3[2:1] == 2'b01) begin
            s.f3[2] = 1'b1;
          end
          s.imm   = XLEN'((tgt - i) * 4);
          prog[i] = {s.imm[12], s.imm[10:5], s.rs2, s.rs1, s.f3,
                     s.imm[4:1], s.imm[11], OPC_BRANCH};
        end
        K_JAL: begin
          s.imm   = XLEN'((tgt - i) * 4);
          prog[i] = {s.imm[20], s.imm[10:1], s.imm[11], s.imm[19:12], s.rd, OPC_JAL};
        end
        default: begin
          // jalr from x0 lands on an absolute forward address
          s.rs1   = '0;
          s.f3    = '0;
          s.imm   = XLEN'(tgt * 4);
          prog[i] = {s.imm[11:0], s.rs1, s.f3, s.rd, OPC_JALR};
        end
      endcase
      slots[i] = s;
    end
    // closing self-loop, jal x0,0
    s                 = '0;
    s.kind            = K_JAL;
    slots[PROG_LEN-1] = s;
    prog[PROG_LEN-1]  = {25'b0, OPC_JAL};
  endfunction

  // ====================
  // reference model
  // ====================

  function automatic void run_model();
    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    logic [XLEN-1:0] nxt;
    logic            take;
    slot_t           s;
    retire_t         r;
    exp_q.delete();
    for (int k = 0; k < 32; k++) begin
      regs[k] = '0;
    end
    pc = RESET_PC;
    // all control flow is forward, the self-loop comes within PROG_LEN steps
    for (int step = 0; step < PROG_LEN; step++) begin
      s   = slots[pc[6:2]];
      a   = regs[s.rs1];
      b   = (s.kind == K_REG || s.kind == K_BRANCH) ? regs[s.rs2] : s.imm;
      nxt = pc + XLEN'(4);
      case (s.f3)
        3'd0: res = s.alt ? a - b : a + b;
        3'd1: res = a << b[4:0];
        3'd2: res = XLEN'($signed(a) < $signed(b));
        3'd3: res = XLEN'(a < b);
        3'd4: res = a ^ b;
        3'd5: res = s.alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: res = a | b;
        default: res = a & b;
      endcase
      case (s.f3)
        3'd0: take = (a == b);
        3'd1: take = (a != b);
        3'd4: take = ($signed(a) < $signed(b));
        3'd5: take = ($signed(a) >= $signed(b));
        3'd6: take = (a < b);
        default: take = (a >= b);
      endcase
      case (s.kind)
        K_UPPER: res = s.alt ? pc + s.imm : s.imm;
        K_BRANCH: nxt = take ? pc + s.imm : nxt;
        K_JAL, K_JALR: begin
          res = pc + XLEN'(4);
          nxt = (s.kind == K_JAL) ? pc + s.imm : (a + s.imm) & ~XLEN'(1);
        end
        default: ;
      endcase
      r.valid     = 1'b1;
      r.pc        = pc;
      r.rd        = s.rd;
      r.reg_write = (s.kind != K_BRANCH);
      r.wdata     = res;
      exp_q.push_back(r);
      if (r.reg_write && s.rd != '0) begin
        regs[s.rd] = res;
      end
      if (nxt == pc) begin
        break;
      end
      pc = nxt;
    end
  endfunction

endpackage

//--- tb/tb_rv_core.sv
module tb_rv_core
  import rv_pkg::*, rv_model_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic            clk;
  logic            rst;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] inst;
  retire_t         retire;
  int              err_count   = 0;
  int              pass_count  = 0;
  int              fail_count  = 0;
  int              cycles      = 0;
  int              cycle_limit = 0;

  rv_core dut_i (
    .clk_i    (clk),
    .rst_i    (rst),
    .pc_o     (pc),
    .inst_i   (inst),
    .retire_o (retire)
  );

  always #2 clk = ~clk;

  // instruction memory returns nop past the end of the program
  always @(negedge clk) begin
    if (pc < XLEN'(PROG_LEN * 4)) begin
      inst <= prog[pc[6:2]];
    end else begin
      inst <= NOP_INST;
    end
  end

  // limit grows by each test's share as the test starts
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, expected retires never arrived", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ====================
  // checks
  // ====================

  task automatic check_retire(input string name, input retire_t exp, input retire_t got);
    if (got.pc !== exp.pc) begin
      $display("MISMATCH %s pc expected %08h actual %08h", name, exp.pc, got.pc);
      err_count++;
    end
    if (exp.reg_write && (exp.rd != '0)) begin
      if ((got.reg_write !== 1'b1) || (got.rd !== exp.rd)) begin
        $display("MISMATCH %s rd at pc %08h expected x%0d write 1 actual x%0d write %0b",
                 name, exp.pc, exp.rd, got.rd, got.reg_write);
        err_count++;
      end
      if (got.wdata !== exp.wdata) begin
        $display("MISMATCH %s wdata at pc %08h expected %08h actual %08h",
                 name, exp.pc, exp.wdata, got.wdata);
        err_count++;
      end
    end
  endtask

  task automatic run_test(input int test_id, input string name);
    int errs_before;
    int idx;
    errs_before = err_count;
    gen_program(test_id);
    run_model();
    cycle_limit += 3 * exp_q.size() + 20;
    rst = 1'b1;
    repeat (5) begin
      @(negedge clk);
      if (retire.valid !== 1'b0) begin
        $display("%s: retire valid was raised while reset was held", name);
        err_count++;
      end
      // fetch starts from address zero
      if (pc !== XLEN'(0)) begin
        $display("MISMATCH %s pc_o in reset expected %08h actual %08h",
                 name, XLEN'(0), pc);
        err_count++;
      end
    end
    rst = 1'b0;
    idx = 0;
    while (idx < exp_q.size()) begin
      @(negedge clk);
      if (retire.valid) begin
        check_retire(name, exp_q[idx], retire);
        idx++;
      end
    end
    if (err_count == errs_before) begin
      $display("test %s passed, %0d instructions retired", name, idx);
      pass_count++;
    end else begin
      $display("test %s failed with %0d errors", name, err_count - errs_before);
      fail_count++;
    end
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin
    void'($urandom(94986));
    clk  = 1'b0;
    rst  = 1'b1;
    inst <= NOP_INST;
    run_test(1, "reset_start");
    run_test(2, "alu_reg");
    run_test(3, "alu_imm_upper");
    run_test(4, "forwarding");
    run_test(5, "branches");
    run_test(6, "jumps");
    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             pass_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
